//--- mmio_pkg.sv
package mmio_pkg;

    // Data and address word on the load/store path
    typedef logic [31:0] word_t;

    // One UART character
    typedef logic [7:0] byte_t;

    // Register offset inside the I/O page
    typedef logic [7:0] io_offset_t;

    // Top address nibble that selects the I/O page
    localparam logic [3:0] IO_PAGE = 4'h8;

    // UART status, bit 1 rx byte held, bit 0 tx idle
    localparam io_offset_t OFF_UART_CTRL = 8'h00;
    // Received byte, read pops it
    localparam io_offset_t OFF_UART_RX = 8'h04;
    // Byte to transmit, store only
    localparam io_offset_t OFF_UART_TX = 8'h08;

    // Performance counters
    localparam io_offset_t OFF_CYCLE = 8'h10;
    localparam io_offset_t OFF_INST = 8'h14;
    // Any load or store here clears every counter
    localparam io_offset_t OFF_CNT_CLEAR = 8'h18;
    localparam io_offset_t OFF_BRANCH = 8'h1C;
    localparam io_offset_t OFF_BR_CORRECT = 8'h20;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            tx_valid,
    input  mmio_pkg::byte_t tx_data,
    output logic            tx_ready,
    output logic            serial_out
);

    // Clocks per bit and the counter that spans one bit time
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    mmio_pkg::tx_state_t state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [2:0]          bit_idx;
    mmio_pkg::byte_t     shift_reg;
    logic                bit_end;

    assign bit_end = (bit_cnt == BIT_LAST);

    // Only an idle transmitter takes a new byte
    assign tx_ready = (state == mmio_pkg::TX_IDLE);

    // Bit-time counter restarts at every bit boundary
    always_ff @(posedge clk) begin
        if (rst || state == mmio_pkg::TX_IDLE || bit_end) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmio_pkg::TX_IDLE;
            serial_out <= 1'b1;
            bit_idx <= '0;
        end else begin
            case (state)
                mmio_pkg::TX_IDLE: begin
                    if (tx_valid) begin
                        // Start bit goes out right away
                        state <= mmio_pkg::TX_START;
                        serial_out <= 1'b0;
                    end
                end
                mmio_pkg::TX_START: begin
                    if (bit_end) begin
                        state <= mmio_pkg::TX_DATA;
                        serial_out <= shift_reg[0];
                        bit_idx <= '0;
                    end
                end
                mmio_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= mmio_pkg::TX_STOP;
                            serial_out <= 1'b1;
                        end else begin
                            serial_out <= shift_reg[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    // Stop bit already on the line
                    if (bit_end) begin
                        state <= mmio_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first, next bit always sits in shift_reg[0]
    always_ff @(posedge clk) begin
        if (state == mmio_pkg::TX_IDLE && tx_valid) begin
            shift_reg <= tx_data;
        end else if (bit_end && state != mmio_pkg::TX_STOP) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // Line rests high between frames
    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        state == mmio_pkg::TX_IDLE |-> serial_out);

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            serial_in,
    input  logic            rx_ready,
    output logic            rx_valid,
    output mmio_pkg::byte_t rx_data
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    // Mid-point of the start bit, counted from the falling edge
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    mmio_pkg::rx_state_t state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [2:0]          bit_idx;
    mmio_pkg::byte_t     shift_reg;
    logic                sync_a;
    logic                sync_b;
    logic                half_end;
    logic                bit_end;
    logic                frame_done;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_a <= 1'b1;
            sync_b <= 1'b1;
        end else begin
            sync_a <= serial_in;
            sync_b <= sync_a;
        end
    end

    assign half_end = (state == mmio_pkg::RX_START) && (bit_cnt == HALF_LAST);
    assign bit_end = (state != mmio_pkg::RX_START) && (bit_cnt == BIT_LAST);
    // Good stop bit seen at its middle
    assign frame_done = (state == mmio_pkg::RX_STOP) && bit_end && sync_b;

    always_ff @(posedge clk) begin
        if (rst || state == mmio_pkg::RX_IDLE || half_end || bit_end) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmio_pkg::RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                mmio_pkg::RX_IDLE: begin
                    // Falling edge starts a frame
                    if (!sync_b) begin
                        state <= mmio_pkg::RX_START;
                    end
                end
                mmio_pkg::RX_START: begin
                    // Glitch if the line is back high at mid-bit
                    if (half_end) begin
                        state <= sync_b ? mmio_pkg::RX_IDLE : mmio_pkg::RX_DATA;
                        bit_idx <= '0;
                    end
                end
                mmio_pkg::RX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= mmio_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    // Low stop bit drops the byte
                    if (bit_end) begin
                        state <= mmio_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == mmio_pkg::RX_DATA && bit_end) begin
            shift_reg <= {sync_b, shift_reg[7:1]};
        end
    end

    // Holding register, a new byte overwrites an unread one
    always_ff @(posedge clk) begin
        if (frame_done) begin
            rx_data <= shift_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else if (frame_done) begin
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

endmodule

//--- perf_counters.sv
`timescale 1ns/1ps

module perf_counters (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear,
    input  logic            retire,
    input  logic            branch,
    input  logic            branch_ok,
    output mmio_pkg::word_t cycle_cnt,
    output mmio_pkg::word_t inst_cnt,
    output mmio_pkg::word_t branch_cnt,
    output mmio_pkg::word_t br_ok_cnt
);

    localparam int NUM_CNT = 4;

    // Index 0 cycles, 1 retired, 2 branches, 3 correct branches
    mmio_pkg::word_t    cnt [NUM_CNT];
    logic [NUM_CNT-1:0] inc;

    // Cycle counter runs freely, the others follow their events
    assign inc = {branch_ok, branch, retire, 1'b1};

    // Shared clear wins over any event in the same cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst || clear) begin
                cnt[i] <= '0;
            end else if (inc[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign cycle_cnt = cnt[0];
    assign inst_cnt = cnt[1];
    assign branch_cnt = cnt[2];
    assign br_ok_cnt = cnt[3];

    // A correct branch is always also a resolved branch
    a_ok_is_branch: assert property (@(posedge clk) disable iff (rst)
        branch_ok |-> branch);

endmodule

//--- mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 store,
    input  mmio_pkg::word_t      addr,
    input  mmio_pkg::word_t      wdata,
    input  logic                 tx_ready,
    input  logic                 rx_valid,
    input  mmio_pkg::byte_t      rx_data,
    input  mmio_pkg::word_t      cycle_cnt,
    input  mmio_pkg::word_t      inst_cnt,
    input  mmio_pkg::word_t      branch_cnt,
    input  mmio_pkg::word_t      br_ok_cnt,
    output mmio_pkg::word_t      rdata,
    output logic                 tx_valid,
    output mmio_pkg::byte_t      tx_data,
    output logic                 rx_ready,
    output logic                 clear
);

    logic                 io_sel;
    mmio_pkg::io_offset_t offset;
    mmio_pkg::word_t      status;
    mmio_pkg::word_t      rd_mux;

    // Page comes from the top nibble and register from the low byte
    assign io_sel = (addr[31:28] == mmio_pkg::IO_PAGE);
    assign offset = addr[7:0];

    assign status = {30'b0, rx_valid, tx_ready};

    // Read select is zero outside the I/O page and on holes
    always_comb begin
        rd_mux = '0;
        if (io_sel) begin
            case (offset)
                mmio_pkg::OFF_UART_CTRL:  rd_mux = status;
                mmio_pkg::OFF_UART_RX:    rd_mux = {24'b0, rx_data};
                mmio_pkg::OFF_CYCLE:      rd_mux = cycle_cnt;
                mmio_pkg::OFF_INST:       rd_mux = inst_cnt;
                mmio_pkg::OFF_BRANCH:     rd_mux = branch_cnt;
                mmio_pkg::OFF_BR_CORRECT: rd_mux = br_ok_cnt;
                default:                  rd_mux = '0;
            endcase
        end
    end

    // Read data lands one cycle after the load and holds
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (load) begin
            rdata <= rd_mux;
        end
    end

    // The UART drops a transmit strobe while busy
    assign tx_valid = store && io_sel && (offset == mmio_pkg::OFF_UART_TX);
    assign tx_data = wdata[7:0];

    // Reading the rx register pops the held byte
    assign rx_ready = load && io_sel && (offset == mmio_pkg::OFF_UART_RX);

    // Either access type clears the counters
    assign clear = (load || store) && io_sel && (offset == mmio_pkg::OFF_CNT_CLEAR);

    // Core issues at most one memory op per cycle
    a_one_access: assert property (@(posedge clk) disable iff (rst)
        !(load && store));

endmodule

//--- cpu_io.sv
`timescale 1ns/1ps

module cpu_io #(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            store,
    input  mmio_pkg::word_t addr,
    input  mmio_pkg::word_t wdata,
    input  logic            retire,
    input  logic            branch,
    input  logic            branch_ok,
    input  logic            serial_in,
    output mmio_pkg::word_t rdata,
    output logic            serial_out
);

    // UART side of the register block
    logic            tx_valid;
    logic            tx_ready;
    mmio_pkg::byte_t tx_data;
    logic            rx_valid;
    logic            rx_ready;
    mmio_pkg::byte_t rx_data;

    // Counter side
    logic            clear;
    mmio_pkg::word_t cycle_cnt;
    mmio_pkg::word_t inst_cnt;
    mmio_pkg::word_t branch_cnt;
    mmio_pkg::word_t br_ok_cnt;

    mmio_regs regs (
        .clk(clk),
        .rst(rst),
        .load(load),
        .store(store),
        .addr(addr),
        .wdata(wdata),
        .tx_ready(tx_ready),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .cycle_cnt(cycle_cnt),
        .inst_cnt(inst_cnt),
        .branch_cnt(branch_cnt),
        .br_ok_cnt(br_ok_cnt),
        .rdata(rdata),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .rx_ready(rx_ready),
        .clear(clear)
    );

    uart_tx #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) tx (
        .clk(clk),
        .rst(rst),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_ready(tx_ready),
        .serial_out(serial_out)
    );

    uart_rx #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) rx (
        .clk(clk),
        .rst(rst),
        .serial_in(serial_in),
        .rx_ready(rx_ready),
        .rx_valid(rx_valid),
        .rx_data(rx_data)
    );

    perf_counters counters (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .retire(retire),
        .branch(branch),
        .branch_ok(branch_ok),
        .cycle_cnt(cycle_cnt),
        .inst_cnt(inst_cnt),
        .branch_cnt(branch_cnt),
        .br_ok_cnt(br_ok_cnt)
    );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            store,
    input  mmio_pkg::word_t addr,
    input  mmio_pkg::word_t wdata,
    input  logic            retire,
    input  logic            branch,
    input  logic            branch_ok,
    input  mmio_pkg::word_t rdata,
    input  logic            serial_out,
    input  int              test_num,
    input  logic            test_end,
    output int              err_count,
    output int              pass_tests,
    output int              fail_tests
);

    // Frame is 10 bits of 10 clocks
    localparam int BIT_CLKS = 10;
    localparam int TX_BUSY = 100;
    // Receiver flags the byte this many edges after acceptance
    localparam int RX_LAT = 98;

    string           names [1:6];
    mmio_pkg::word_t m_cnt [4];
    mmio_pkg::byte_t tx_q [$];
    mmio_pkg::byte_t rx_next;
    mmio_pkg::byte_t m_rx_byte;
    mmio_pkg::byte_t frame;
    mmio_pkg::word_t exp_rd;
    logic            m_rx_valid;
    logic            pend;
    logic            prev_s;
    logic            in_frame;
    logic            is_io;
    logic [7:0]      off;
    int              busy;
    int              rx_timer;
    int              pos;
    int              test_errs;

    initial begin
        names[1] = "reset values";
        names[2] = "uart transmit";
        names[3] = "uart loopback receive";
        names[4] = "event counters";
        names[5] = "counter clear";
        names[6] = "busy transmit drop";
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        test_errs = 0;
        pend = 1'b0;
        prev_s = 1'b1;
        in_frame = 1'b0;
        pos = 0;
        busy = 0;
        rx_timer = 0;
        m_rx_valid = 1'b0;
        m_rx_byte = '0;
        for (int i = 0; i < 4; i++) begin
            m_cnt[i] = '0;
        end
    end

    // Expected register value from the current model state
    function automatic mmio_pkg::word_t model_read(input mmio_pkg::word_t a);
        model_read = '0;
        if (a[31:28] == mmio_pkg::IO_PAGE) begin
            case (a[7:0])
                mmio_pkg::OFF_UART_CTRL:  model_read = {30'b0, m_rx_valid, busy == 0};
                mmio_pkg::OFF_UART_RX:    model_read = {24'b0, m_rx_byte};
                mmio_pkg::OFF_CYCLE:      model_read = m_cnt[0];
                mmio_pkg::OFF_INST:       model_read = m_cnt[1];
                mmio_pkg::OFF_BRANCH:     model_read = m_cnt[2];
                mmio_pkg::OFF_BR_CORRECT: model_read = m_cnt[3];
                default:                  model_read = '0;
            endcase
        end
    endfunction

    always @(posedge clk) begin
        // rdata from the last load has been stable since that edge
        if (pend) begin
            pend = 1'b0;
            if (rdata !== exp_rd) begin
                $display("Error at %0t: rdata expected %h got %h", $time, exp_rd, rdata);
                err_count++;
                test_errs++;
            end
        end

        is_io = (addr[31:28] == mmio_pkg::IO_PAGE);
        off = addr[7:0];
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                m_cnt[i] = '0;
            end
            busy = 0;
            rx_timer = 0;
            m_rx_valid = 1'b0;
            tx_q.delete();
        end else begin
            if (load) begin
                exp_rd = model_read(addr);
                pend = 1'b1;
            end
            // Clear wins over counter events
            if ((load || store) && is_io && off == mmio_pkg::OFF_CNT_CLEAR) begin
                for (int i = 0; i < 4; i++) begin
                    m_cnt[i] = '0;
                end
            end else begin
                m_cnt[0] = m_cnt[0] + 1;
                if (retire) begin
                    m_cnt[1] = m_cnt[1] + 1;
                end
                if (branch) begin
                    m_cnt[2] = m_cnt[2] + 1;
                end
                if (branch_ok) begin
                    m_cnt[3] = m_cnt[3] + 1;
                end
            end
            // Transmitter takes bytes only when idle
            if (store && is_io && off == mmio_pkg::OFF_UART_TX && busy == 0) begin
                tx_q.push_back(wdata[7:0]);
                rx_next = wdata[7:0];
                busy = TX_BUSY;
                rx_timer = RX_LAT;
            end else begin
                if (busy > 0) begin
                    busy--;
                end
                if (rx_timer > 0) begin
                    if (rx_timer == 1) begin
                        m_rx_valid = 1'b1;
                        m_rx_byte = rx_next;
                    end else if (load && is_io && off == mmio_pkg::OFF_UART_RX) begin
                        m_rx_valid = 1'b0;
                    end
                    rx_timer--;
                end else if (load && is_io && off == mmio_pkg::OFF_UART_RX) begin
                    m_rx_valid = 1'b0;
                end
            end
        end

        // Frame decode samples mid-bit and watches for early edges
        if (!in_frame) begin
            if (!rst && prev_s && !serial_out) begin
                in_frame = 1'b1;
                pos = 0;
            end
        end else begin
            pos++;
            if (pos % BIT_CLKS != 0 && serial_out != prev_s) begin
                $display("Error at %0t: serial_out edge %0d cycles into a bit", $time,
                    pos % BIT_CLKS);
                err_count++;
                test_errs++;
            end
            if (pos % BIT_CLKS == 5) begin
                if (pos / BIT_CLKS == 0 && serial_out !== 1'b0) begin
                    $display("Error at %0t: serial_out start bit expected 0 got %b",
                        $time, serial_out);
                    err_count++;
                    test_errs++;
                end else if (pos / BIT_CLKS >= 1 && pos / BIT_CLKS <= 8) begin
                    frame = {serial_out, frame[7:1]};
                end else if (pos / BIT_CLKS == 9) begin
                    if (serial_out !== 1'b1) begin
                        $display("Error at %0t: serial_out stop bit expected 1 got %b",
                            $time, serial_out);
                        err_count++;
                        test_errs++;
                    end
                    if (tx_q.size() == 0) begin
                        $display("Frame %h on serial_out with no accepted byte", frame);
                        err_count++;
                        test_errs++;
                    end else if (frame !== tx_q[0]) begin
                        $display("Error at %0t: serial_out byte expected %h got %h",
                            $time, tx_q[0], frame);
                        err_count++;
                        test_errs++;
                        void'(tx_q.pop_front());
                    end else begin
                        void'(tx_q.pop_front());
                    end
                    in_frame = 1'b0;
                end
            end
        end
        prev_s = serial_out;

        if (test_end) begin
            if (tx_q.size() != 0) begin
                $display("Accepted transmit byte never appeared on serial_out");
                err_count++;
                test_errs++;
                tx_q.delete();
            end
            if (test_errs == 0) begin
                pass_tests++;
                $display("Test %0d %s: pass", test_num, names[test_num]);
            end else begin
                fail_tests++;
                $display("Test %0d %s: fail, %0d errors", test_num, names[test_num],
                    test_errs);
            end
            test_errs = 0;
        end
    end

endmodule

//--- tb_cpu_io.sv
`timescale 1ns/1ps

module tb_cpu_io;

    localparam int CLOCK_FREQ = 50_000_000;
    localparam int BAUD_RATE = 5_000_000;
    localparam int POLL_LIMIT = 2000;

    logic            clk;
    logic            rst;
    logic            load;
    logic            store;
    mmio_pkg::word_t addr;
    mmio_pkg::word_t wdata;
    logic            retire;
    logic            branch;
    logic            branch_ok;
    mmio_pkg::word_t rdata;
    logic            serial_out;
    wire             serial_loop;
    int              test_num;
    logic            test_end;
    int              err_count;
    int              pass_tests;
    int              fail_tests;
    logic [15:0]     lfsr;
    mmio_pkg::word_t rd_val;
    mmio_pkg::word_t rnd;

    // Transmitter feeds the receiver directly
    assign serial_loop = serial_out;

    cpu_io #(
        .CLOCK_FREQ(CLOCK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .load(load),
        .store(store),
        .addr(addr),
        .wdata(wdata),
        .retire(retire),
        .branch(branch),
        .branch_ok(branch_ok),
        .serial_in(serial_loop),
        .rdata(rdata),
        .serial_out(serial_out)
    );

    tb_checker chk (
        .clk(clk),
        .rst(rst),
        .load(load),
        .store(store),
        .addr(addr),
        .wdata(wdata),
        .retire(retire),
        .branch(branch),
        .branch_ok(branch_ok),
        .rdata(rdata),
        .serial_out(serial_out),
        .test_num(test_num),
        .test_end(test_end),
        .err_count(err_count),
        .pass_tests(pass_tests),
        .fail_tests(fail_tests)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit taken
    function automatic mmio_pkg::word_t take_bits(input int n);
        logic fb;
        take_bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            take_bits = {take_bits[30:0], fb};
        end
    endfunction

    function automatic mmio_pkg::word_t io_addr(input mmio_pkg::io_offset_t off);
        io_addr = {mmio_pkg::IO_PAGE, 20'h0, off};
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One-cycle load with rdata valid after the next edge
    task automatic read_reg(input mmio_pkg::word_t a, output mmio_pkg::word_t v);
        @(posedge clk);
        #2;
        load = 1'b1;
        addr = a;
        @(posedge clk);
        #2;
        load = 1'b0;
        v = rdata;
    endtask

    task automatic write_reg(input mmio_pkg::word_t a, input mmio_pkg::word_t d);
        @(posedge clk);
        #2;
        store = 1'b1;
        addr = a;
        wdata = d;
        @(posedge clk);
        #2;
        store = 1'b0;
    endtask

    // Poll the status word until the chosen bit is set
    task automatic wait_status(input int bit_pos, input string what);
        mmio_pkg::word_t v;
        int polls;
        polls = 0;
        v = '0;
        while (v[bit_pos] !== 1'b1 && polls < POLL_LIMIT) begin
            read_reg(io_addr(mmio_pkg::OFF_UART_CTRL), v);
            polls++;
        end
        if (v[bit_pos] !== 1'b1) begin
            $display("Timeout after %0d status polls waiting for %s", polls, what);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic finish_test();
        @(posedge clk);
        #2;
        test_end = 1'b1;
        @(posedge clk);
        #2;
        test_end = 1'b0;
        test_num++;
    endtask

    initial begin
        lfsr = 16'h0001;
        rst = 1'b1;
        load = 1'b0;
        store = 1'b0;
        addr = '0;
        wdata = '0;
        retire = 1'b0;
        branch = 1'b0;
        branch_ok = 1'b0;
        test_num = 1;
        test_end = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset values, holes and non-I/O space
        read_reg(io_addr(mmio_pkg::OFF_UART_CTRL), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_CYCLE), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_INST), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BRANCH), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BR_CORRECT), rd_val);
        read_reg(io_addr(8'h0C), rd_val);
        read_reg(32'h1000_0010, rd_val);
        finish_test();

        // Random bytes out through the transmitter
        for (int i = 0; i < 4; i++) begin
            wait_status(0, "tx ready");
            rnd = take_bits(8);
            write_reg(io_addr(mmio_pkg::OFF_UART_TX), rnd);
        end
        wait_status(0, "tx ready after last byte");
        finish_test();

        // Loopback receive after dropping any byte left from before
        read_reg(io_addr(mmio_pkg::OFF_UART_RX), rd_val);
        for (int i = 0; i < 3; i++) begin
            wait_status(0, "tx ready");
            rnd = take_bits(8);
            write_reg(io_addr(mmio_pkg::OFF_UART_TX), rnd);
            wait_status(1, "rx valid");
            read_reg(io_addr(mmio_pkg::OFF_UART_RX), rd_val);
            read_reg(io_addr(mmio_pkg::OFF_UART_CTRL), rd_val);
        end
        wait_status(0, "tx ready");
        finish_test();

        // Random event pulses
        rnd = take_bits(6);
        for (int i = 0; i < 20 + int'(rnd[5:0]); i++) begin
            @(posedge clk);
            #2;
            rd_val = take_bits(3);
            retire = rd_val[0];
            branch = rd_val[1];
            branch_ok = rd_val[1] & rd_val[2];
        end
        @(posedge clk);
        #2;
        retire = 1'b0;
        branch = 1'b0;
        branch_ok = 1'b0;
        read_reg(io_addr(mmio_pkg::OFF_INST), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BRANCH), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BR_CORRECT), rd_val);
        finish_test();

        // Clear with events in the same cycle
        @(posedge clk);
        #2;
        store = 1'b1;
        addr = io_addr(mmio_pkg::OFF_CNT_CLEAR);
        retire = 1'b1;
        branch = 1'b1;
        branch_ok = 1'b1;
        @(posedge clk);
        #2;
        store = 1'b0;
        retire = 1'b0;
        branch = 1'b0;
        branch_ok = 1'b0;
        rnd = take_bits(4);
        idle_cycles(int'(rnd[3:0]));
        read_reg(io_addr(mmio_pkg::OFF_CYCLE), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_INST), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BRANCH), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_BR_CORRECT), rd_val);
        // Clear by a load as well
        read_reg(io_addr(mmio_pkg::OFF_CNT_CLEAR), rd_val);
        read_reg(io_addr(mmio_pkg::OFF_CYCLE), rd_val);
        finish_test();

        // Second store while busy must vanish
        wait_status(0, "tx ready");
        write_reg(io_addr(mmio_pkg::OFF_UART_TX), 32'h0000_00A5);
        write_reg(io_addr(mmio_pkg::OFF_UART_TX), 32'h0000_005A);
        wait_status(0, "tx ready after busy store");
        idle_cycles(20);
        finish_test();

        idle_cycles(2);
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
            pass_tests, fail_tests, err_count);
        if (err_count == 0 && fail_tests == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
mmio_pkg.sv
uart_tx.sv
uart_rx.sv
perf_counters.sv
mmio_regs.sv
cpu_io.sv
tb_checker.sv
tb_cpu_io.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_cpu_io -o sim_cpu_io

./obj_dir/sim_cpu_io > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    exit 1
fi
exit 0
